// File: logic/l1_cache_pkg.sv
// l1 cache shared definitions
package l1_cache_pkg;

    // geometry, fixed for this cache
    localparam int WORD_W      = 32;
    localparam int CACHE_BYTES = 1024;
    localparam int BLOCK_WORDS = 2;                  // words per frame
    localparam int N_WAYS      = 2;
    localparam int N_SETS      = CACHE_BYTES / (N_WAYS * BLOCK_WORDS * WORD_W / 8); // 64
    localparam int SET_BITS    = $clog2(N_SETS);
    localparam int WORD_BITS   = $clog2(BLOCK_WORDS);
    localparam int WAY_BITS    = $clog2(N_WAYS);
    localparam int BYTE_BITS   = 2;                  // byte offset in a word
    localparam int TAG_BITS    = WORD_W - SET_BITS - WORD_BITS - BYTE_BITS; // 23

    // everything at or above this bypasses the cache
    localparam logic [WORD_W-1:0] NONCACHE_BASE = 32'h8000_0000;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [WORD_W/8-1:0] byte_en_t;    // one bit per byte lane
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [SET_BITS-1:0] set_idx_t;
    typedef logic [WORD_BITS-1:0] word_idx_t;
    typedef logic [WAY_BITS-1:0] way_idx_t;

    // address split, msb first
    typedef struct packed {
        tag_t                 tag;
        set_idx_t             set_idx;
        word_idx_t            word_idx;
        logic [BYTE_BITS-1:0] byte_off;
    } decoded_addr_t;

    typedef enum logic [2:0] {
        IDLE,
        WB,            // victim write-back
        FETCH,         // block fill
        FLUSH_SCAN,    // look for dirty frames
        FLUSH_FRAME    // write one dirty frame out
    } ctrl_state_t;

    typedef enum logic [2:0] {
        TAG_NONE,
        TAG_TOUCH,         // hit way becomes last used
        TAG_SET_DIRTY,     // write hit
        TAG_FILL,          // new tag, valid, clean
        TAG_CLEAN_VICTIM,
        TAG_CLEAN_SWEEP
    } tag_op_t;

    typedef enum logic [1:0] {
        DATA_NONE,
        DATA_MERGE,    // byte lanes from the processor
        DATA_FILL      // full word from memory
    } data_op_t;

endpackage

// File: logic/tag_store.sv
// tag, state and lru arrays
`timescale 1ns/100ps

module tag_store (
    input  logic                   CLK,
    input  logic                   nRST,
    input  l1_cache_pkg::word_t    proc_addr,
    input  l1_cache_pkg::tag_op_t  tag_op,
    input  l1_cache_pkg::set_idx_t sweep_set,
    input  l1_cache_pkg::way_idx_t sweep_way,
    output logic                   hit,
    output l1_cache_pkg::way_idx_t hit_way,
    output l1_cache_pkg::way_idx_t victim_way,
    output logic                   victim_dirty,
    output l1_cache_pkg::tag_t     victim_tag,
    output logic                   sweep_dirty,
    output l1_cache_pkg::tag_t     sweep_tag
);
    import l1_cache_pkg::*;

    logic [N_WAYS-1:0] valid [N_SETS];
    logic [N_WAYS-1:0] dirty [N_SETS];
    tag_t              tags  [N_SETS][N_WAYS];
    way_idx_t          lru   [N_SETS];    // way used last

    decoded_addr_t     req;
    logic [N_WAYS-1:0] way_hit;

    assign req = proc_addr;

    // compare request tag in every way
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < N_WAYS; w++) begin
            way_hit[w] = valid[req.set_idx][w] && (tags[req.set_idx][w] == req.tag);
            if (way_hit[w]) begin
                hit_way = way_idx_t'(w);
            end
        end
    end

    assign hit = |way_hit;

    // replace the way not used last
    assign victim_way   = ~lru[req.set_idx];
    assign victim_dirty = valid[req.set_idx][victim_way] & dirty[req.set_idx][victim_way];
    assign victim_tag   = tags[req.set_idx][victim_way];

    assign sweep_dirty = valid[sweep_set][sweep_way] & dirty[sweep_set][sweep_way];
    assign sweep_tag   = tags[sweep_set][sweep_way];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < N_SETS; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
                lru[s]   <= '0;
            end
        end else begin
            case (tag_op)
                TAG_TOUCH: lru[req.set_idx] <= hit_way;
                TAG_SET_DIRTY: begin
                    dirty[req.set_idx][hit_way] <= 1'b1;
                    lru[req.set_idx]            <= hit_way;
                end
                TAG_FILL: begin
                    valid[req.set_idx][victim_way] <= 1'b1;
                    dirty[req.set_idx][victim_way] <= 1'b0;
                    lru[req.set_idx]               <= victim_way;  // fill counts as use
                end
                TAG_CLEAN_VICTIM: dirty[req.set_idx][victim_way] <= 1'b0;
                TAG_CLEAN_SWEEP:  dirty[sweep_set][sweep_way]    <= 1'b0;
                default: ;
            endcase
        end
    end

    // tag payload, written on fill only
    always_ff @(posedge CLK) begin
        if (tag_op == TAG_FILL) begin
            tags[req.set_idx][victim_way] <= req.tag;
        end
    end

    // fills only go to a missing tag, so a set never holds it twice
    assert property (@(posedge CLK) disable iff (!nRST) $onehot0(way_hit));

endmodule

// File: logic/data_store.sv
// block data array
`timescale 1ns/100ps

module data_store (
    input  logic                    CLK,
    input  logic                    nRST,
    input  l1_cache_pkg::set_idx_t  data_set,
    input  l1_cache_pkg::way_idx_t  data_way,
    input  l1_cache_pkg::word_idx_t data_word,
    input  l1_cache_pkg::data_op_t  data_op,
    input  l1_cache_pkg::word_t     proc_wdata,
    input  l1_cache_pkg::byte_en_t  proc_byte_en,
    input  l1_cache_pkg::word_t     mem_rdata,
    output l1_cache_pkg::word_t     rdata
);
    import l1_cache_pkg::*;

    // 64 sets x 2 ways x 2 words
    word_t blocks [N_SETS][N_WAYS][BLOCK_WORDS];
    word_t merged;   // current word with enabled lanes replaced

    assign rdata = blocks[data_set][data_way][data_word];

    // per-lane merge for hit writes
    always_comb begin
        merged = rdata;
        for (int b = 0; b < WORD_W / 8; b++) begin
            if (proc_byte_en[b]) begin
                merged[8*b +: 8] = proc_wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (nRST) begin     // no writes while reset held
            case (data_op)
                DATA_MERGE: blocks[data_set][data_way][data_word] <= merged;
                DATA_FILL:  blocks[data_set][data_way][data_word] <= mem_rdata;
                default: ;
            endcase
        end
    end

endmodule

// File: logic/walk_counters.sv
// burst and flush walk counters
`timescale 1ns/100ps

module walk_counters (
    input  logic                             CLK,
    input  logic                             nRST,
    input  logic                             word_en,
    input  logic                             word_clr,
    input  logic                             way_en,
    input  logic                             way_clr,
    input  logic                             set_en,
    input  logic                             set_clr,
    output logic [l1_cache_pkg::WORD_BITS:0] word_num,
    output logic [l1_cache_pkg::WAY_BITS:0]  way_num,
    output logic [l1_cache_pkg::SET_BITS:0]  set_num,
    output logic                             word_done,
    output logic                             way_done,
    output logic                             set_done
);
    import l1_cache_pkg::*;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            word_num <= '0;
            way_num  <= '0;
            set_num  <= '0;
        end else begin
            if (word_clr) begin
                word_num <= '0;          // clear wins over enable
            end else if (word_en) begin
                word_num <= word_num + 1'b1;
            end
            if (way_clr) begin
                way_num <= '0;
            end else if (way_en) begin
                way_num <= way_num + 1'b1;
            end
            if (set_clr) begin
                set_num <= '0;
            end else if (set_en) begin
                set_num <= set_num + 1'b1;
            end
        end
    end

    // done once the count is one past the last index
    assign word_done = (word_num == (WORD_BITS + 1)'(BLOCK_WORDS));
    assign way_done  = (way_num == (WAY_BITS + 1)'(N_WAYS));
    assign set_done  = (set_num == (SET_BITS + 1)'(N_SETS));

    // controller stops stepping once a count is done
    assert property (@(posedge CLK) disable iff (!nRST) word_en && !word_clr |-> !word_done);
    assert property (@(posedge CLK) disable iff (!nRST) way_en && !way_clr |-> !way_done);
    assert property (@(posedge CLK) disable iff (!nRST) set_en && !set_clr |-> !set_done);

endmodule

// File: logic/cache_ctrl.sv
// cache controller FSM
`timescale 1ns/100ps

module cache_ctrl (
    input  logic                             CLK,
    input  logic                             nRST,
    input  l1_cache_pkg::word_t              proc_addr,
    input  logic                             proc_ren,
    input  logic                             proc_wen,
    input  l1_cache_pkg::byte_en_t           proc_byte_en,
    output logic                             proc_busy,
    output l1_cache_pkg::word_t              mem_addr,
    output logic                             mem_ren,
    output logic                             mem_wen,
    output l1_cache_pkg::byte_en_t           mem_byte_en,
    input  logic                             mem_busy,
    output logic                             mem_sel_cache,
    input  logic                             flush,
    output logic                             flush_done,
    input  logic                             hit,
    input  l1_cache_pkg::way_idx_t           hit_way,
    input  l1_cache_pkg::way_idx_t           victim_way,
    input  logic                             victim_dirty,
    input  l1_cache_pkg::tag_t               victim_tag,
    input  logic                             sweep_dirty,
    input  l1_cache_pkg::tag_t               sweep_tag,
    output l1_cache_pkg::tag_op_t            tag_op,
    output l1_cache_pkg::set_idx_t           sweep_set,
    output l1_cache_pkg::way_idx_t           sweep_way,
    output l1_cache_pkg::data_op_t           data_op,
    output l1_cache_pkg::set_idx_t           data_set,
    output l1_cache_pkg::way_idx_t           data_way,
    output l1_cache_pkg::word_idx_t          data_word,
    input  logic [l1_cache_pkg::WORD_BITS:0] word_num,
    input  logic [l1_cache_pkg::WAY_BITS:0]  way_num,
    input  logic [l1_cache_pkg::SET_BITS:0]  set_num,
    input  logic                             word_done,
    input  logic                             way_done,
    input  logic                             set_done,
    output logic                             word_en,
    output logic                             word_clr,
    output logic                             way_en,
    output logic                             way_clr,
    output logic                             set_en,
    output logic                             set_clr
);
    import l1_cache_pkg::*;

    ctrl_state_t   state, next_state;
    decoded_addr_t req;
    logic          req_any;     // read or write pending
    logic          req_write;   // read wins if both are up
    logic          pass;        // non-cacheable region
    word_idx_t     burst_word;  // word within the burst

    assign req        = proc_addr;
    assign req_any    = proc_ren | proc_wen;
    assign req_write  = proc_wen & ~proc_ren;
    assign pass       = (proc_addr >= NONCACHE_BASE);
    assign burst_word = word_num[WORD_BITS-1:0];

    // flush walk position
    assign sweep_set = set_num[SET_BITS-1:0];
    assign sweep_way = way_num[WAY_BITS-1:0];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state    = state;
        proc_busy     = 1'b1;
        mem_addr      = proc_addr;
        mem_ren       = 1'b0;
        mem_wen       = 1'b0;
        mem_byte_en   = '1;         // bursts move whole words
        mem_sel_cache = 1'b1;
        flush_done    = 1'b0;
        tag_op        = TAG_NONE;
        data_op       = DATA_NONE;
        data_set      = req.set_idx;
        data_way      = hit_way;
        data_word     = req.word_idx;
        word_en       = 1'b0;
        word_clr      = 1'b0;
        way_en        = 1'b0;
        way_clr       = 1'b0;
        set_en        = 1'b0;
        set_clr       = 1'b0;

        case (state)
            IDLE: begin
                if (req_any && pass) begin
                    // straight to memory, done when memory is
                    mem_ren       = proc_ren;
                    mem_wen       = req_write;
                    mem_byte_en   = proc_byte_en;
                    mem_sel_cache = 1'b0;
                    proc_busy     = mem_busy;
                end else if (req_any && hit) begin
                    proc_busy = 1'b0;   // same-cycle hit
                    if (req_write) begin
                        tag_op  = TAG_SET_DIRTY;
                        data_op = DATA_MERGE;
                    end else begin
                        tag_op = TAG_TOUCH;
                    end
                end else if (req_any) begin
                    next_state = victim_dirty ? WB : FETCH;  // miss
                end else if (flush) begin
                    next_state = FLUSH_SCAN;
                end
            end

            WB: begin
                data_way  = victim_way;
                data_word = burst_word;
                mem_addr  = {victim_tag, req.set_idx, burst_word, {BYTE_BITS{1'b0}}};
                if (word_done) begin
                    word_clr   = 1'b1;
                    tag_op     = TAG_CLEAN_VICTIM;
                    next_state = FETCH;
                end else begin
                    mem_wen = 1'b1;
                    word_en = !mem_busy;    // hold on back-pressure
                end
            end

            FETCH: begin
                data_way  = victim_way;
                data_word = burst_word;
                mem_addr  = {req.tag, req.set_idx, burst_word, {BYTE_BITS{1'b0}}};
                if (word_done) begin
                    word_clr   = 1'b1;
                    tag_op     = TAG_FILL;
                    next_state = IDLE;      // request hits there
                end else begin
                    mem_ren = 1'b1;
                    if (!mem_busy) begin
                        word_en = 1'b1;
                        data_op = DATA_FILL;
                    end
                end
            end

            FLUSH_SCAN: begin
                if (set_done) begin
                    flush_done = 1'b1;
                    set_clr    = 1'b1;
                    next_state = IDLE;
                end else if (way_done) begin
                    way_clr = 1'b1;         // next set
                    set_en  = 1'b1;
                end else if (sweep_dirty) begin
                    next_state = FLUSH_FRAME;
                end else begin
                    way_en = 1'b1;          // clean, skip
                end
            end

            FLUSH_FRAME: begin
                data_set  = sweep_set;
                data_way  = sweep_way;
                data_word = burst_word;
                mem_addr  = {sweep_tag, sweep_set, burst_word, {BYTE_BITS{1'b0}}};
                if (word_done) begin
                    word_clr   = 1'b1;
                    way_en     = 1'b1;
                    tag_op     = TAG_CLEAN_SWEEP;
                    next_state = FLUSH_SCAN;
                end else begin
                    mem_wen = 1'b1;
                    word_en = !mem_busy;
                end
            end

            default: next_state = IDLE;
        endcase
    end

    // one memory strobe at a time across every state
    assert property (@(posedge CLK) disable iff (!nRST) !(mem_ren && mem_wen));

    // a stalled strobe keeps its address until memory accepts it
    assert property (@(posedge CLK) disable iff (!nRST)
        (mem_ren || mem_wen) && mem_busy |=> $stable(mem_addr) && (mem_ren || mem_wen));

endmodule

// File: logic/l1_cache.sv
// l1 cache top
`timescale 1ns/100ps

module l1_cache (
    input  logic                     CLK,
    input  logic                     nRST,
    // processor side
    input  l1_cache_pkg::word_t      proc_addr,
    input  logic                     proc_ren,
    input  logic                     proc_wen,
    input  l1_cache_pkg::word_t      proc_wdata,
    input  l1_cache_pkg::byte_en_t   proc_byte_en,
    output l1_cache_pkg::word_t      proc_rdata,
    output logic                     proc_busy,
    // memory side
    output l1_cache_pkg::word_t      mem_addr,
    output logic                     mem_ren,
    output logic                     mem_wen,
    output l1_cache_pkg::word_t      mem_wdata,
    output l1_cache_pkg::byte_en_t   mem_byte_en,
    input  l1_cache_pkg::word_t      mem_rdata,
    input  logic                     mem_busy,
    // flush
    input  logic                     flush,
    output logic                     flush_done
);
    import l1_cache_pkg::*;

    // tag store lookups
    logic      hit;
    way_idx_t  hit_way;
    way_idx_t  victim_way;
    logic      victim_dirty;
    tag_t      victim_tag;
    logic      sweep_dirty;
    tag_t      sweep_tag;

    // controller commands
    tag_op_t   tag_op;
    set_idx_t  sweep_set;
    way_idx_t  sweep_way;
    data_op_t  data_op;
    set_idx_t  data_set;
    way_idx_t  data_way;
    word_idx_t data_word;
    logic      mem_sel_cache;   // low only for pass-through
    word_t     rdata;

    // walk counters
    logic [WORD_BITS:0] word_num;
    logic [WAY_BITS:0]  way_num;
    logic [SET_BITS:0]  set_num;
    logic word_done, way_done, set_done;
    logic word_en, word_clr, way_en, way_clr, set_en, set_clr;

    assign proc_rdata = mem_sel_cache ? rdata : mem_rdata;   // pass-through reads go straight back
    assign mem_wdata  = mem_sel_cache ? rdata : proc_wdata;  // write-back data or processor word

    cache_ctrl    u_ctrl     (.*);
    tag_store     u_tags     (.*);
    data_store    u_data     (.*);
    walk_counters u_counters (.*);

endmodule

// File: tb/mem_model.sv
// backing memory model
`timescale 1ns/100ps

module mem_model (
    input  logic                   CLK,
    input  logic                   nRST,
    input  l1_cache_pkg::word_t    mem_addr,
    input  logic                   mem_ren,
    input  logic                   mem_wen,
    input  l1_cache_pkg::word_t    mem_wdata,
    input  l1_cache_pkg::byte_en_t mem_byte_en,
    output l1_cache_pkg::word_t    mem_rdata,
    output logic                   mem_busy,
    input  l1_cache_pkg::word_t    peek_addr,
    output l1_cache_pkg::word_t    peek_data,
    output int                     read_count,
    output int                     write_count
);
    import l1_cache_pkg::*;

    word_t      words [4096];  // indexed by address bits 13:2
    logic [7:0] lfsr;          // busy delay source
    logic [7:0] lfsr_next;     // one step ahead
    logic [1:0] delay;         // busy cycles left on this transfer

    // galois lfsr, the bit taken is the old lsb
    function automatic logic [7:0] lfsr_step(logic [7:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 8'hB8;
        end
        return s >> 1;
    endfunction

    assign lfsr_next = lfsr_step(lfsr);
    assign mem_busy  = (mem_ren || mem_wen) && (delay != 2'd0);
    assign mem_rdata = words[mem_addr[13:2]];   // read data follows the address
    assign peek_data = words[peek_addr[13:2]];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < 4096; i++) begin
                words[i] <= word_t'(i * 4) ^ 32'hA5A5_0000;   // byte address pattern
            end
            lfsr        <= 8'd24;
            delay       <= 2'd0;
            read_count  <= 0;
            write_count <= 0;
        end else if (mem_ren || mem_wen) begin
            if (delay != 2'd0) begin
                delay <= delay - 2'd1;   // still stalling
            end else begin
                if (mem_wen) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_byte_en[b]) begin
                            words[mem_addr[13:2]][8*b +: 8] <= mem_wdata[8*b +: 8];
                        end
                    end
                    write_count <= write_count + 1;
                end else begin
                    read_count <= read_count + 1;
                end
                // two bits, two steps, for the next stall
                delay <= {lfsr[0], lfsr_next[0]};
                lfsr  <= lfsr_step(lfsr_next);
            end
        end
    end

endmodule

// File: tb/l1_cache_tb.sv
// l1 cache testbench
`timescale 1ns/100ps

module l1_cache_tb;
    import l1_cache_pkg::*;

    localparam int WAIT_LIMIT = 1000;   // cycles per wait, flush scan included
    localparam word_t NC_ADDR = 32'h8000_3F00;   // clear of the cached words below

    typedef enum {READ, WRITE, FLUSH, PEEK} op_t;
    typedef struct {
        op_t      op;
        word_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
        word_t    exp_word;   // read data, or memory word for PEEK
        int       reads;      // memory read transfers caused by the row
        int       writes;     // memory write transfers caused by the row
    } row_t;

    logic     CLK, nRST;
    word_t    proc_addr, proc_wdata, proc_rdata;
    logic     proc_ren, proc_wen, proc_busy;
    byte_en_t proc_byte_en, mem_byte_en;
    word_t    mem_addr, mem_wdata, mem_rdata;
    logic     mem_ren, mem_wen, mem_busy;
    logic     flush, flush_done;
    word_t    peek_addr, peek_data;
    int       read_count, write_count;
    row_t     rows [$];

    l1_cache  dut (.*);
    mem_model mem (.*);

    initial CLK = 1'b0;
    always #4 CLK = ~CLK;   // 8 ns period

    // memory contents before any write
    function automatic word_t init_word(word_t addr);
        return {18'b0, addr[13:2], 2'b00} ^ 32'hA5A5_0000;
    endfunction

    function automatic word_t merge_lanes(word_t old_word, word_t new_word, byte_en_t be);
        word_t w;
        w = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                w[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return w;
    endfunction

    function automatic void add_row(op_t op, word_t addr, word_t wdata, byte_en_t be,
                                    word_t exp_word, int reads, int writes);
        rows.push_back('{op, addr, wdata, be, exp_word, reads, writes});
    endfunction

    task automatic stop_run(string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp) begin
            stop_run($sformatf("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    // poll at the falling edge, return 1 ns after the completing edge
    task automatic wait_for(bit want_flush, string what, output word_t rdata);
        int n;
        n = 0;
        @(negedge CLK);
        while (want_flush ? !flush_done : proc_busy) begin
            if (n == WAIT_LIMIT) begin
                stop_run({"timeout: ", what, " did not finish within the wait limit"});
            end
            n++;
            @(negedge CLK);
        end
        rdata = proc_rdata;
        @(posedge CLK);
        #1;
    endtask

    function automatic void build_table();
        word_t w40, v40, v44, vnc, v104;
        w40  = merge_lanes(init_word(32'h40), 32'h1122_3344, 4'b0001);
        v40  = merge_lanes(w40, 32'hAABB_CCDD, 4'b0110);
        v44  = 32'h0BAD_F00D;
        vnc  = merge_lanes(init_word(NC_ADDR), 32'hCAFE_F00D, 4'b0110);
        v104 = merge_lanes(init_word(32'h104), 32'h7788_99AA, 4'b1100);
        // cold fill, then the other word with no new fetch
        add_row(READ,  32'h40, '0, '0, init_word(32'h40), 2, 0);
        add_row(READ,  32'h44, '0, '0, init_word(32'h44), 0, 0);
        // masked hit writes, each read back
        add_row(WRITE, 32'h40, 32'h1122_3344, 4'b0001, '0, 0, 0);
        add_row(READ,  32'h40, '0, '0, w40, 0, 0);
        add_row(WRITE, 32'h40, 32'hAABB_CCDD, 4'b0110, '0, 0, 0);
        add_row(READ,  32'h40, '0, '0, v40, 0, 0);
        add_row(WRITE, 32'h44, v44, 4'b1111, '0, 0, 0);
        add_row(READ,  32'h44, '0, '0, v44, 0, 0);
        // set 8 gets a third tag, dirty lru frame goes out
        add_row(READ,  32'h240, '0, '0, init_word(32'h240), 2, 0);
        add_row(READ,  32'h440, '0, '0, init_word(32'h440), 2, 2);
        add_row(PEEK,  32'h40, '0, '0, v40, 0, 0);
        add_row(PEEK,  32'h44, '0, '0, v44, 0, 0);
        add_row(READ,  32'h40, '0, '0, v40, 2, 0);   // evicts the clean 0x240
        add_row(READ,  32'h44, '0, '0, v44, 0, 0);
        // non-cacheable region
        add_row(READ,  NC_ADDR, '0, '0, init_word(NC_ADDR), 1, 0);
        add_row(WRITE, NC_ADDR, 32'hCAFE_F00D, 4'b0110, '0, 0, 1);
        add_row(READ,  NC_ADDR, '0, '0, vnc, 1, 0);
        add_row(PEEK,  NC_ADDR, '0, '0, vnc, 0, 0);
        add_row(READ,  32'h40, '0, '0, v40, 0, 0);   // cache untouched
        add_row(READ,  32'h440, '0, '0, init_word(32'h440), 0, 0);
        // two dirty frames, then flush twice
        add_row(WRITE, 32'h440, 32'h5555_AAAA, 4'b1111, '0, 0, 0);
        add_row(WRITE, 32'h104, 32'h7788_99AA, 4'b1100, '0, 2, 0);   // write miss
        add_row(FLUSH, '0, '0, '0, '0, 0, 4);
        add_row(PEEK,  32'h440, '0, '0, 32'h5555_AAAA, 0, 0);
        add_row(PEEK,  32'h444, '0, '0, init_word(32'h444), 0, 0);
        add_row(PEEK,  32'h104, '0, '0, v104, 0, 0);
        add_row(PEEK,  32'h100, '0, '0, init_word(32'h100), 0, 0);
        add_row(FLUSH, '0, '0, '0, '0, 0, 0);         // nothing left dirty
        add_row(READ,  32'h104, '0, '0, v104, 0, 0);
    endfunction

    initial begin
        int    rd0, wr0;
        word_t got;
        nRST         = 1'b0;
        proc_addr    = '0;
        proc_ren     = 1'b0;
        proc_wen     = 1'b0;
        proc_wdata   = '0;
        proc_byte_en = '0;
        flush        = 1'b0;
        peek_addr    = '0;
        build_table();
        repeat (16) @(posedge CLK);
        #1;
        nRST = 1'b1;

        // idle after reset, no strobes and no done pulse
        repeat (8) begin
            @(negedge CLK);
            check_bit("flush_done", flush_done, 1'b0);
            check_bit("mem_ren", mem_ren, 1'b0);
            check_bit("mem_wen", mem_wen, 1'b0);
            check_bit("proc_busy", proc_busy, 1'b1);
        end
        @(posedge CLK);
        #1;

        foreach (rows[i]) begin
            rd0 = read_count;
            wr0 = write_count;
            case (rows[i].op)
                READ: begin
                    proc_addr = rows[i].addr;
                    proc_ren  = 1'b1;
                    wait_for(1'b0, "read", got);
                    proc_ren  = 1'b0;
                    check_word($sformatf("proc_rdata @%h", rows[i].addr), got, rows[i].exp_word);
                end
                WRITE: begin
                    proc_addr    = rows[i].addr;
                    proc_wdata   = rows[i].wdata;
                    proc_byte_en = rows[i].byte_en;
                    proc_wen     = 1'b1;
                    wait_for(1'b0, "write", got);
                    proc_wen     = 1'b0;
                end
                FLUSH: begin
                    flush = 1'b1;
                    wait_for(1'b1, "flush", got);
                    flush = 1'b0;
                end
                default: begin   // PEEK at the memory model
                    peek_addr = rows[i].addr;
                    @(negedge CLK);
                    check_word($sformatf("mem word @%h", rows[i].addr), peek_data,
                               rows[i].exp_word);
                    @(posedge CLK);
                    #1;
                end
            endcase
            check_count($sformatf("mem reads row %0d", i), read_count - rd0, rows[i].reads);
            check_count($sformatf("mem writes row %0d", i), write_count - wr0, rows[i].writes);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

// File: sim.f
logic/l1_cache_pkg.sv
logic/tag_store.sv
logic/data_store.sv
logic/walk_counters.sv
logic/cache_ctrl.sv
logic/l1_cache.sv
tb/mem_model.sv
tb/l1_cache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the l1 cache testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module l1_cache_tb -f sim.f -o sim_l1_cache
./obj_dir/sim_l1_cache | tee sim.log

if grep -q "All tests passed" sim.log; then
    echo "simulation PASS"
else
    echo "simulation FAIL"
    exit 1
fi
